/* board_mgmt_pkg.sv */
// Board management package: sizes, register map and sideband types
package board_mgmt_pkg;

    localparam int CAGE_COUNT  = 2;
    localparam int SYNC_STAGES = 2;
    localparam int WB_ADDR_W   = 4;
    localparam int WB_DATA_W   = 32;

    typedef logic [WB_ADDR_W-1:0] wb_addr_t;
    typedef logic [WB_DATA_W-1:0] wb_data_t;

    // Word addresses, cage k sits at ADDR_CAGE_BASE + k
    localparam wb_addr_t ADDR_CAGE_BASE = 4'd0;
    localparam wb_addr_t ADDR_I2C       = 4'd8;
    localparam wb_addr_t ADDR_BOARD_ID  = 4'd15;

    localparam wb_data_t BOARD_ID = 32'h1172_B00E;

    // Cage word layout
    localparam int CTRL_RESET_L_BIT   = 0;
    localparam int CTRL_LPMODE_BIT    = 1;
    localparam int CTRL_MODSEL_L_BIT  = 2;
    localparam int STAT_MODPRS_L_BIT  = 8;
    localparam int STAT_INT_L_BIT     = 9;
    localparam int STAT_INT_EVENT_BIT = 16;

    // I2C word layout
    localparam int I2C_FPGA_SCL_BIT   = 0;
    localparam int I2C_FPGA_SDA_BIT   = 1;
    localparam int I2C_QSFPDD_SCL_BIT = 2;
    localparam int I2C_QSFPDD_SDA_BIT = 3;
    localparam int I2C_DRIVE_LSB      = 0;
    localparam int I2C_LINES_LSB      = 8;

    typedef struct packed {
        logic reset_l;
        logic lpmode;
        logic modsel_l;
    } cage_ctrl_t;

    typedef struct packed {
        logic modprs_l;
        logic int_l;
    } cage_status_t;

    typedef cage_status_t [CAGE_COUNT-1:0] cage_status_vec_t;

    typedef struct packed {
        logic fpga_scl;
        logic fpga_sda;
        logic qsfpdd_scl;
        logic qsfpdd_sda;
    } i2c_lines_t;

    // Module held in reset, low power, deselected
    localparam cage_ctrl_t CTRL_RESET_VALUE = '{reset_l: 1'b0, lpmode: 1'b1, modsel_l: 1'b1};

    // Register bit order of the four I2C lines
    function automatic logic [3:0] i2c_pack(i2c_lines_t lines);
        logic [3:0] bits;
        bits = '0;
        bits[I2C_FPGA_SCL_BIT]   = lines.fpga_scl;
        bits[I2C_FPGA_SDA_BIT]   = lines.fpga_sda;
        bits[I2C_QSFPDD_SCL_BIT] = lines.qsfpdd_scl;
        bits[I2C_QSFPDD_SDA_BIT] = lines.qsfpdd_sda;
        return bits;
    endfunction

    function automatic i2c_lines_t i2c_unpack(logic [3:0] bits);
        i2c_lines_t lines;
        lines.fpga_scl   = bits[I2C_FPGA_SCL_BIT];
        lines.fpga_sda   = bits[I2C_FPGA_SDA_BIT];
        lines.qsfpdd_scl = bits[I2C_QSFPDD_SCL_BIT];
        lines.qsfpdd_sda = bits[I2C_QSFPDD_SDA_BIT];
        return lines;
    endfunction

endpackage

/* status_sync.sv */
// Status synchronizer: register chain bringing asynchronous pin levels onto pcie_clk
`timescale 1ns/1ps

module status_sync import board_mgmt_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     pcie_clk,
    input  logic     arst_n_i,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t sync_q [SYNC_STAGES];

    // Idle level of active-low and pulled-up lines is all ones
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                sync_q[i] <= '1;
            end
        end else begin
            sync_q[0] <= data_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign data_o = sync_q[SYNC_STAGES-1];

endmodule

/* cage_ctrl.sv */
// QSFP-DD cage controller: control pins, status readback and sticky interrupt flag
`timescale 1ns/1ps

module cage_ctrl import board_mgmt_pkg::*; (
    input  logic         pcie_clk,
    input  logic         arst_n_i,

    input  logic         wr_en_i,
    input  wb_data_t     wr_data_i,

    input  cage_status_t status_i,
    output cage_ctrl_t   ctrl_o,
    output wb_data_t     word_o
);

    cage_ctrl_t ctrl_q;
    logic       event_q;

    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= CTRL_RESET_VALUE;
        end else if (wr_en_i) begin
            ctrl_q.reset_l  <= wr_data_i[CTRL_RESET_L_BIT];
            ctrl_q.lpmode   <= wr_data_i[CTRL_LPMODE_BIT];
            ctrl_q.modsel_l <= wr_data_i[CTRL_MODSEL_L_BIT];
        end
    end

    // Sticky flag, a pending interrupt wins over a clear
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            event_q <= 1'b0;
        end else if (!status_i.int_l) begin
            event_q <= 1'b1;
        end else if (wr_en_i && wr_data_i[STAT_INT_EVENT_BIT]) begin
            event_q <= 1'b0;
        end
    end

    assign ctrl_o = ctrl_q;

    always_comb begin
        word_o = '0;
        word_o[CTRL_RESET_L_BIT]   = ctrl_q.reset_l;
        word_o[CTRL_LPMODE_BIT]    = ctrl_q.lpmode;
        word_o[CTRL_MODSEL_L_BIT]  = ctrl_q.modsel_l;
        word_o[STAT_MODPRS_L_BIT]  = status_i.modprs_l;
        word_o[STAT_INT_L_BIT]     = status_i.int_l;
        word_o[STAT_INT_EVENT_BIT] = event_q;
    end

endmodule

/* i2c_bitbang.sv */
// I2C bit-bang block: drive registers and open-drain pads for the FPGA and QSFP-DD buses
`timescale 1ns/1ps

module i2c_bitbang import board_mgmt_pkg::*; (
    input  logic       pcie_clk,
    input  logic       arst_n_i,

    input  logic       wr_en_i,
    input  wb_data_t   wr_data_i,
    output i2c_lines_t drive_o,

    inout  wire        fpga_i2c_scl_io,
    inout  wire        fpga_i2c_sda_io,
    inout  wire        qsfpdd_i2c_scl_io,
    inout  wire        qsfpdd_i2c_sda_io
);

    // 1 releases the line, 0 pulls it low
    i2c_lines_t drive_q;
    i2c_lines_t pad_q;

    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            drive_q <= '1;
        end else if (wr_en_i) begin
            drive_q <= i2c_unpack(wr_data_i[I2C_DRIVE_LSB +: 4]);
        end
    end

    // Output stage next to the pads
    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pad_q <= '1;
        end else begin
            pad_q <= drive_q;
        end
    end

    assign drive_o = drive_q;

    assign fpga_i2c_scl_io   = pad_q.fpga_scl   ? 1'bz : 1'b0;
    assign fpga_i2c_sda_io   = pad_q.fpga_sda   ? 1'bz : 1'b0;
    assign qsfpdd_i2c_scl_io = pad_q.qsfpdd_scl ? 1'bz : 1'b0;
    assign qsfpdd_i2c_sda_io = pad_q.qsfpdd_sda ? 1'bz : 1'b0;

endmodule

/* mgmt_wb_slave.sv */
// Wishbone classic slave: single-cycle ack, address decode and registered read mux
`timescale 1ns/1ps

module mgmt_wb_slave import board_mgmt_pkg::*; (
    input  logic                  pcie_clk,
    input  logic                  arst_n_i,

    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  wb_addr_t              wb_adr_i,
    input  wb_data_t              wb_dat_i,
    output wb_data_t              wb_dat_o,
    output logic                  wb_ack_o,

    output logic [CAGE_COUNT-1:0] cage_wr_en_o,
    output wb_data_t              wr_data_o,
    input  wb_data_t              cage_word_i [CAGE_COUNT],

    output logic                  i2c_wr_en_o,
    input  i2c_lines_t            i2c_drive_i,
    input  i2c_lines_t            i2c_lines_i
);

    logic     ack_q;
    logic     req;
    logic     wr_req;
    wb_data_t rd_data;
    wb_data_t rd_q;

    // New request only while ack is low, the master holds until it sees ack
    assign req    = wb_cyc_i && wb_stb_i && !ack_q;
    assign wr_req = req && wb_we_i;

    always_ff @(posedge pcie_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_comb begin
        cage_wr_en_o = '0;
        for (int k = 0; k < CAGE_COUNT; k++) begin
            if (wb_adr_i == wb_addr_t'(ADDR_CAGE_BASE + k)) begin
                cage_wr_en_o[k] = wr_req;
            end
        end
    end

    assign i2c_wr_en_o = wr_req && (wb_adr_i == ADDR_I2C);
    assign wr_data_o   = wb_dat_i;

    // Unmapped words read as zero
    always_comb begin
        rd_data = '0;
        for (int k = 0; k < CAGE_COUNT; k++) begin
            if (wb_adr_i == wb_addr_t'(ADDR_CAGE_BASE + k)) begin
                rd_data = cage_word_i[k];
            end
        end
        if (wb_adr_i == ADDR_I2C) begin
            rd_data[I2C_DRIVE_LSB +: 4] = i2c_pack(i2c_drive_i);
            rd_data[I2C_LINES_LSB +: 4] = i2c_pack(i2c_lines_i);
        end
        if (wb_adr_i == ADDR_BOARD_ID) begin
            rd_data = BOARD_ID;
        end
    end

    // Captured with the request, valid while ack is high
    always_ff @(posedge pcie_clk) begin
        if (req) begin
            rd_q <= rd_data;
        end
    end

    assign wb_dat_o = rd_q;
    assign wb_ack_o = ack_q;

endmodule

/* board_mgmt.sv */
// Board management top: QSFP-DD cage sideband and I2C buses behind a Wishbone slave
`timescale 1ns/1ps

module board_mgmt import board_mgmt_pkg::*; (
    input  logic                  pcie_clk,
    input  logic                  arst_n_i,

    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  wb_addr_t              wb_adr_i,
    input  wb_data_t              wb_dat_i,
    output wb_data_t              wb_dat_o,
    output logic                  wb_ack_o,

    output logic [CAGE_COUNT-1:0] qsfpdd_modsel_l_o,
    output logic [CAGE_COUNT-1:0] qsfpdd_reset_l_o,
    output logic [CAGE_COUNT-1:0] qsfpdd_lpmode_o,
    input  logic [CAGE_COUNT-1:0] qsfpdd_modprs_l_i,
    input  logic [CAGE_COUNT-1:0] qsfpdd_int_l_i,

    inout  wire                   fpga_i2c_scl_io,
    inout  wire                   fpga_i2c_sda_io,
    inout  wire                   qsfpdd_i2c_scl_io,
    inout  wire                   qsfpdd_i2c_sda_io
);

    cage_status_vec_t      cage_pins;
    cage_status_vec_t      cage_status;
    cage_ctrl_t            cage_ctrl_w [CAGE_COUNT];
    wb_data_t              cage_word [CAGE_COUNT];
    logic [CAGE_COUNT-1:0] cage_wr_en;
    wb_data_t              wr_data;

    i2c_lines_t            pad_lines;
    i2c_lines_t            i2c_lines;
    i2c_lines_t            i2c_drive;
    logic                  i2c_wr_en;

    status_sync #(
        .payload_t(cage_status_vec_t)
    ) u_cage_sync (
        .pcie_clk (pcie_clk),
        .arst_n_i (arst_n_i),
        .data_i   (cage_pins),
        .data_o   (cage_status)
    );

    generate
        for (genvar k = 0; k < CAGE_COUNT; k++) begin : g_cage
            assign cage_pins[k].modprs_l = qsfpdd_modprs_l_i[k];
            assign cage_pins[k].int_l    = qsfpdd_int_l_i[k];

            cage_ctrl u_cage_ctrl (
                .pcie_clk  (pcie_clk),
                .arst_n_i  (arst_n_i),
                .wr_en_i   (cage_wr_en[k]),
                .wr_data_i (wr_data),
                .status_i  (cage_status[k]),
                .ctrl_o    (cage_ctrl_w[k]),
                .word_o    (cage_word[k])
            );

            assign qsfpdd_reset_l_o[k]  = cage_ctrl_w[k].reset_l;
            assign qsfpdd_lpmode_o[k]   = cage_ctrl_w[k].lpmode;
            assign qsfpdd_modsel_l_o[k] = cage_ctrl_w[k].modsel_l;
        end
    endgenerate

    // Wired-AND pad levels as seen from outside
    assign pad_lines.fpga_scl   = fpga_i2c_scl_io;
    assign pad_lines.fpga_sda   = fpga_i2c_sda_io;
    assign pad_lines.qsfpdd_scl = qsfpdd_i2c_scl_io;
    assign pad_lines.qsfpdd_sda = qsfpdd_i2c_sda_io;

    status_sync #(
        .payload_t(i2c_lines_t)
    ) u_i2c_sync (
        .pcie_clk (pcie_clk),
        .arst_n_i (arst_n_i),
        .data_i   (pad_lines),
        .data_o   (i2c_lines)
    );

    i2c_bitbang u_i2c (
        .pcie_clk          (pcie_clk),
        .arst_n_i          (arst_n_i),
        .wr_en_i           (i2c_wr_en),
        .wr_data_i         (wr_data),
        .drive_o           (i2c_drive),
        .fpga_i2c_scl_io   (fpga_i2c_scl_io),
        .fpga_i2c_sda_io   (fpga_i2c_sda_io),
        .qsfpdd_i2c_scl_io (qsfpdd_i2c_scl_io),
        .qsfpdd_i2c_sda_io (qsfpdd_i2c_sda_io)
    );

    mgmt_wb_slave u_wb_slave (
        .pcie_clk     (pcie_clk),
        .arst_n_i     (arst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .cage_wr_en_o (cage_wr_en),
        .wr_data_o    (wr_data),
        .cage_word_i  (cage_word),
        .i2c_wr_en_o  (i2c_wr_en),
        .i2c_drive_i  (i2c_drive),
        .i2c_lines_i  (i2c_lines)
    );

endmodule

/* tb_board_mgmt.sv */
// Board management testbench: random Wishbone traffic and pin toggles against a reference model
`timescale 1ns/1ps

module tb_board_mgmt import board_mgmt_pkg::*; ();

    localparam int unsigned SEED   = 32'h976c4b6d;
    localparam int N_OPS           = 400;
    localparam int RESET_CYCLES    = 4;
    localparam int SETTLE          = SYNC_STAGES + 2;
    localparam int ACK_LIMIT       = 16;
    // Random ops, reset, and the sweep of all 16 words after reset
    localparam int CYCLE_LIMIT     = N_OPS * 12 + RESET_CYCLES + 16 * 3 + SETTLE + 8;

    logic                  pcie_clk;
    logic                  arst_n_i;
    logic                  wb_cyc_i;
    logic                  wb_stb_i;
    logic                  wb_we_i;
    wb_addr_t              wb_adr_i;
    wb_data_t              wb_dat_i;
    wb_data_t              wb_dat_o;
    logic                  wb_ack_o;
    logic [CAGE_COUNT-1:0] modsel_l;
    logic [CAGE_COUNT-1:0] reset_l;
    logic [CAGE_COUNT-1:0] lpmode;
    logic [CAGE_COUNT-1:0] modprs_l;
    logic [CAGE_COUNT-1:0] int_l;
    wire                   fpga_scl;
    wire                   fpga_sda;
    wire                   qsfpdd_scl;
    wire                   qsfpdd_sda;

    // External pull-downs on the I2C buses (1 pulls the line low)
    i2c_lines_t            ext_low;

    // Reference model
    cage_ctrl_t            ctrl_m [CAGE_COUNT];
    logic [CAGE_COUNT-1:0] event_m;
    i2c_lines_t            drive_m;
    int                    cycles;

    pullup (fpga_scl);
    pullup (fpga_sda);
    pullup (qsfpdd_scl);
    pullup (qsfpdd_sda);

    assign fpga_scl   = ext_low.fpga_scl   ? 1'b0 : 1'bz;
    assign fpga_sda   = ext_low.fpga_sda   ? 1'b0 : 1'bz;
    assign qsfpdd_scl = ext_low.qsfpdd_scl ? 1'b0 : 1'bz;
    assign qsfpdd_sda = ext_low.qsfpdd_sda ? 1'b0 : 1'bz;

    board_mgmt u_dut (
        .pcie_clk          (pcie_clk),
        .arst_n_i          (arst_n_i),
        .wb_cyc_i          (wb_cyc_i),
        .wb_stb_i          (wb_stb_i),
        .wb_we_i           (wb_we_i),
        .wb_adr_i          (wb_adr_i),
        .wb_dat_i          (wb_dat_i),
        .wb_dat_o          (wb_dat_o),
        .wb_ack_o          (wb_ack_o),
        .qsfpdd_modsel_l_o (modsel_l),
        .qsfpdd_reset_l_o  (reset_l),
        .qsfpdd_lpmode_o   (lpmode),
        .qsfpdd_modprs_l_i (modprs_l),
        .qsfpdd_int_l_i    (int_l),
        .fpga_i2c_scl_io   (fpga_scl),
        .fpga_i2c_sda_io   (fpga_sda),
        .qsfpdd_i2c_scl_io (qsfpdd_scl),
        .qsfpdd_i2c_sda_io (qsfpdd_sda)
    );

    always #4 pcie_clk = ~pcie_clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    always @(posedge pcie_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            fail_run("Timeout: the run did not finish within the cycle limit");
        end
    end

    task automatic check_word(input string name, input wb_data_t exp, input wb_data_t act);
        if (exp !== act) begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            fail_run("A register read returned a wrong value");
        end
    endtask

    task automatic check_cage_pins(input string name, input cage_ctrl_t exp,
                                   input cage_ctrl_t act);
        if (exp !== act) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            fail_run("A cage control pin has a wrong level");
        end
    endtask

    task automatic check_i2c_pins(input string name, input i2c_lines_t exp,
                                  input i2c_lines_t act);
        if (exp !== act) begin
            $display("Error: %s expected %b actual %b", name, exp, act);
            fail_run("An I2C pad has a wrong level");
        end
    endtask

    // Wired-AND of the DUT drive and the external pull-downs
    function automatic i2c_lines_t wired_and_levels();
        return i2c_lines_t'(drive_m & ~ext_low);
    endfunction

    function automatic i2c_lines_t pad_levels();
        i2c_lines_t lines;
        lines.fpga_scl   = fpga_scl;
        lines.fpga_sda   = fpga_sda;
        lines.qsfpdd_scl = qsfpdd_scl;
        lines.qsfpdd_sda = qsfpdd_sda;
        return lines;
    endfunction

    function automatic wb_data_t expected_word(input wb_addr_t adr);
        wb_data_t   w;
        i2c_lines_t lines;
        int         k;
        w     = '0;
        lines = wired_and_levels();
        k     = int'(adr) - int'(ADDR_CAGE_BASE);
        if (k >= 0 && k < CAGE_COUNT) begin
            w[CTRL_RESET_L_BIT]   = ctrl_m[k].reset_l;
            w[CTRL_LPMODE_BIT]    = ctrl_m[k].lpmode;
            w[CTRL_MODSEL_L_BIT]  = ctrl_m[k].modsel_l;
            w[STAT_MODPRS_L_BIT]  = modprs_l[k];
            w[STAT_INT_L_BIT]     = int_l[k];
            w[STAT_INT_EVENT_BIT] = event_m[k];
        end else if (adr == ADDR_I2C) begin
            w[I2C_FPGA_SCL_BIT]   = drive_m.fpga_scl;
            w[I2C_FPGA_SDA_BIT]   = drive_m.fpga_sda;
            w[I2C_QSFPDD_SCL_BIT] = drive_m.qsfpdd_scl;
            w[I2C_QSFPDD_SDA_BIT] = drive_m.qsfpdd_sda;
            w[I2C_LINES_LSB + I2C_FPGA_SCL_BIT]   = lines.fpga_scl;
            w[I2C_LINES_LSB + I2C_FPGA_SDA_BIT]   = lines.fpga_sda;
            w[I2C_LINES_LSB + I2C_QSFPDD_SCL_BIT] = lines.qsfpdd_scl;
            w[I2C_LINES_LSB + I2C_QSFPDD_SDA_BIT] = lines.qsfpdd_sda;
        end else if (adr == ADDR_BOARD_ID) begin
            w = BOARD_ID;
        end
        return w;
    endfunction

    // Mostly mapped words and sometimes any word
    function automatic wb_addr_t pick_address();
        int unsigned pick;
        pick = $urandom % 4;
        if (pick == 0) begin
            return wb_addr_t'($urandom % 16);
        end else if (pick == 3) begin
            return ADDR_I2C;
        end
        return wb_addr_t'(ADDR_CAGE_BASE + ($urandom % CAGE_COUNT));
    endfunction

    // Starts on a falling edge and returns on the falling edge that sees ack
    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rdata);
        int waited;
        waited   = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        do begin
            @(negedge pcie_clk);
            waited++;
            if (waited > ACK_LIMIT) begin
                fail_run("A Wishbone access was never acknowledged");
            end
        end while (wb_ack_o !== 1'b1);
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    // A low interrupt line sets the sticky flag
    task automatic settle_model();
        for (int k = 0; k < CAGE_COUNT; k++) begin
            if (!int_l[k]) begin
                event_m[k] = 1'b1;
            end
        end
    endtask

    task automatic check_all_cages(input string name);
        cage_ctrl_t act;
        for (int k = 0; k < CAGE_COUNT; k++) begin
            act.reset_l  = reset_l[k];
            act.lpmode   = lpmode[k];
            act.modsel_l = modsel_l[k];
            check_cage_pins($sformatf("%s cage %0d", name, k), ctrl_m[k], act);
        end
    endtask

    task automatic write_random(input int op);
        wb_addr_t adr;
        wb_data_t wdata;
        wb_data_t rdata;
        int       k;
        adr   = pick_address();
        wdata = $urandom;
        k     = int'(adr) - int'(ADDR_CAGE_BASE);
        wb_access(1'b1, adr, wdata, rdata);
        if (k >= 0 && k < CAGE_COUNT) begin
            ctrl_m[k].reset_l  = wdata[CTRL_RESET_L_BIT];
            ctrl_m[k].lpmode   = wdata[CTRL_LPMODE_BIT];
            ctrl_m[k].modsel_l = wdata[CTRL_MODSEL_L_BIT];
            if (wdata[STAT_INT_EVENT_BIT] && int_l[k]) begin
                event_m[k] = 1'b0;
            end
            settle_model();
        end else if (adr == ADDR_I2C) begin
            drive_m.fpga_scl   = wdata[I2C_FPGA_SCL_BIT];
            drive_m.fpga_sda   = wdata[I2C_FPGA_SDA_BIT];
            drive_m.qsfpdd_scl = wdata[I2C_QSFPDD_SCL_BIT];
            drive_m.qsfpdd_sda = wdata[I2C_QSFPDD_SDA_BIT];
            repeat (SETTLE) @(negedge pcie_clk);
            check_i2c_pins($sformatf("op %0d i2c write", op), wired_and_levels(),
                           pad_levels());
        end
        check_all_cages($sformatf("op %0d write word %0d", op, adr));
    endtask

    task automatic toggle_random_pin(input int op);
        int unsigned sel;
        sel = $urandom % (2 * CAGE_COUNT + 4);
        if (sel < CAGE_COUNT) begin
            modprs_l[sel] = ~modprs_l[sel];
        end else if (sel < 2 * CAGE_COUNT) begin
            int_l[sel - CAGE_COUNT] = ~int_l[sel - CAGE_COUNT];
        end else begin
            ext_low = i2c_lines_t'(ext_low ^ (4'b0001 << (sel - 2 * CAGE_COUNT)));
        end
        repeat (SETTLE) @(negedge pcie_clk);
        settle_model();
        check_i2c_pins($sformatf("op %0d pin toggle", op), wired_and_levels(), pad_levels());
    endtask

    initial begin
        wb_addr_t    adr;
        wb_data_t    rdata;
        int unsigned kind;
        void'($urandom(SEED));
        cycles    = 0;
        pcie_clk  = 1'b0;
        arst_n_i  = 1'b0;
        wb_cyc_i  = 1'b0;
        wb_stb_i  = 1'b0;
        wb_we_i   = 1'b0;
        wb_adr_i  = '0;
        wb_dat_i  = '0;
        modprs_l  = '1;
        int_l     = '1;
        ext_low   = '0;
        for (int k = 0; k < CAGE_COUNT; k++) begin
            ctrl_m[k] = CTRL_RESET_VALUE;
        end
        event_m = '0;
        drive_m = '1;

        repeat (RESET_CYCLES) @(posedge pcie_clk);
        @(negedge pcie_clk);
        arst_n_i = 1'b1;
        repeat (SETTLE) @(negedge pcie_clk);

        check_all_cages("after reset");
        check_i2c_pins("after reset", wired_and_levels(), pad_levels());
        for (int a = 0; a < 16; a++) begin
            wb_access(1'b0, wb_addr_t'(a), '0, rdata);
            check_word($sformatf("after reset word %0d", a), expected_word(wb_addr_t'(a)),
                       rdata);
        end

        for (int op = 0; op < N_OPS; op++) begin
            kind = $urandom % 3;
            if (kind == 0) begin
                write_random(op);
            end else if (kind == 1) begin
                adr = pick_address();
                wb_access(1'b0, adr, $urandom, rdata);
                check_word($sformatf("op %0d read word %0d", op, adr), expected_word(adr),
                           rdata);
            end else begin
                toggle_random_pin(op);
            end
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* all.f */
board_mgmt_pkg.sv
status_sync.sv
cage_ctrl.sv
i2c_bitbang.sv
mgmt_wb_slave.sv
board_mgmt.sv
tb_board_mgmt.sv

/* Bender.yml */
package:
  name: board_mgmt

sources:
  - board_mgmt_pkg.sv
  - status_sync.sv
  - cage_ctrl.sv
  - i2c_bitbang.sv
  - mgmt_wb_slave.sv
  - board_mgmt.sv
  - target: test
    files:
      - tb_board_mgmt.sv
